// File: compile.f
src/riscv_isa_pkg.sv
src/riscv_ctrl_pkg.sv
src/main_decoder.sv
src/alu_decoder.sv
src/imm_extend.sv
src/reg_file.sv
src/alu.sv
src/riscv_core.sv
test/riscv_core_assert.sv
test/tb_riscv_core.sv

// File: test/tb_riscv_core.sv
`timescale 1ns/100ps

module tb_riscv_core
    import riscv_isa_pkg::*;
();

    localparam int          XLEN       = 32;
    localparam logic [31:0] RESET_ADDR = 32'h0;
    localparam int          TIMEOUT    = 200; // cycles per program run

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] instr, read_data, pc, data_adr, write_data;
    logic        mem_write;
    logic [31:0] imem [256];
    logic [31:0] dmem [1024];
    logic [31:0] gold [32];   // expected register contents
    logic [31:0] prog [$], pc_trace [$], st_adr [$], st_data [$], exp_adr [$], exp_data [$];
    logic        wr_trace [$];
    logic [31:0] rng = 32'd79;
    int          fails = 0, tests = 0, failed_tests = 0, test_base = 0;

    always #20 clk = ~clk;

    riscv_core #(.XLEN(XLEN), .RESET_ADDR(RESET_ADDR)) dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .instr_i      (instr),
        .read_data_i  (read_data),
        .pc_o         (pc),
        .data_adr_o   (data_adr),
        .write_data_o (write_data),
        .mem_write_o  (mem_write)
    );

    bind riscv_core riscv_core_assert #(.XLEN(XLEN), .RESET_ADDR(RESET_ADDR)) u_chk (.*);

    assign instr     = rst ? NOP_WORD : imem[pc[9:2]]; // no-op fed during reset
    assign read_data = dmem[data_adr[11:2]];

    always @(posedge clk) begin
        if (mem_write) begin
            dmem[data_adr[11:2]] <= write_data;
        end
        if (!rst) begin
            pc_trace.push_back(pc);
            wr_trace.push_back(mem_write);
            if (mem_write) begin
                st_adr.push_back(data_adr);
                st_data.push_back(write_data);
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] fill_word(int idx);
        return 32'(idx) * 32'h9e37_79b9 + 32'h1234_5678;
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] i_word(opcode_e op, funct3_e f3, int rd, int rs1,
                                           logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] r_word(funct3_e f3, logic sub, int rd, int rs1, int rs2);
        return {1'b0, sub, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic logic [31:0] s_word(int rs2, int rs1, logic [11:0] imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), F3_LW_SW, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_word(int rs1, int rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), F3_BEQ, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(int rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OP_JAL};
    endfunction

    // reference results straight from the RV32I definitions
    function automatic logic [31:0] ref_alu(funct3_e f3, logic sub, logic [31:0] a, logic [31:0] b);
        case (f3)
            F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            F3_OR:   return a | b;
            F3_AND:  return a & b;
            default: return sub ? a - b : a + b;
        endcase
    endfunction

    function automatic int errors();
        return fails + dut.u_chk.fail_count;
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        value_ok: assert (act === exp) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fails++;
        end
    endtask

    task automatic set_reg(int rd, logic [11:0] imm);
        prog.push_back(i_word(OP_IMM, F3_ADD_SUB, rd, 0, imm));
        gold[rd] = sext12(imm);
    endtask

    task automatic store_reg(int rs, logic [11:0] adr);
        prog.push_back(s_word(rs, 0, adr));
        exp_adr.push_back(sext12(adr));
        exp_data.push_back(gold[rs]);
    endtask

    task automatic new_test();
        test_base = errors();
        prog.delete();
        exp_adr.delete();
        exp_data.delete();
    endtask

    task automatic run_program(string name, int cycles);
        int waited;
        repeat (5) @(posedge clk);
        foreach (imem[i]) begin
            imem[i] = (i < prog.size()) ? prog[i] : NOP_WORD;
        end
        pc_trace.delete();
        wr_trace.delete();
        st_adr.delete();
        st_data.delete();
        rst <= 1'b0;
        waited = 0;
        while (pc_trace.size() < cycles && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        rst <= 1'b1; // park the core until the next program
        @(negedge clk);
        if (pc_trace.size() < cycles) begin
            $display("timeout: test %s did not execute %0d instructions", name, cycles);
            fails++;
        end
    endtask

    task automatic check_stores(string name);
        check({name, " store count"}, exp_adr.size(), st_adr.size());
        foreach (exp_adr[i]) begin
            if (i < st_adr.size()) begin
                check({name, " store address"}, exp_adr[i], st_adr[i]);
                check({name, " store data"}, exp_data[i], st_data[i]);
            end
        end
    endtask

    task automatic finish_test(string name);
        tests++;
        if (errors() == test_base) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed", name);
            failed_tests++;
        end
    endtask

    initial begin
        int      rd, rs1, rs2;
        logic    sub;
        funct3_e f3;
        funct3_e alu_f3 [4] = '{F3_ADD_SUB, F3_SLT, F3_OR, F3_AND};

        foreach (dmem[i]) begin
            dmem[i] = fill_word(i);
        end

        new_test();   // empty program runs all no-ops
        run_program("pc_seq", 8);
        for (int i = 0; i < 8; i++) begin
            check("pc_seq", RESET_ADDR + 32'(4 * i), pc_trace[i]);
        end
        finish_test("pc_seq");

        new_test();
        for (int r = 1; r < 8; r++) begin
            rng = xorshift(rng);
            set_reg(r, rng[11:0]);
        end
        for (int n = 0; n < 12; n++) begin
            rng = xorshift(rng);
            rd  = 1 + rng[2:0] % 7;
            rs1 = 1 + rng[5:3] % 7;
            rs2 = 1 + rng[8:6] % 7;
            f3  = alu_f3[rng[10:9]];
            sub = rng[11] && (f3 == F3_ADD_SUB);
            if (rng[12]) begin // immediate form
                prog.push_back(i_word(OP_IMM, f3, rd, rs1, rng[31:20]));
                gold[rd] = ref_alu(f3, 1'b0, gold[rs1], sext12(rng[31:20]));
            end else begin
                prog.push_back(r_word(f3, sub, rd, rs1, rs2));
                gold[rd] = ref_alu(f3, sub, gold[rs1], gold[rs2]);
            end
            store_reg(rd, 12'(4 * n));
        end
        run_program("alu_random", prog.size());
        check_stores("alu_random");
        finish_test("alu_random");

        new_test();
        prog.push_back(i_word(OP_LOAD, F3_LW_SW, 5, 0, 12'h700));
        gold[5] = fill_word(12'h700 >> 2);
        store_reg(5, 12'h100);
        run_program("lw_sw", prog.size());
        check_stores("lw_sw");
        finish_test("lw_sw");

        new_test();
        set_reg(1, 12'd7);
        set_reg(2, 12'd7);
        set_reg(3, 12'd9);
        prog.push_back(b_word(1, 2, 13'd12));   // taken at pc 12 over both stores to 24
        prog.push_back(s_word(1, 0, 12'h300));  // skipped
        prog.push_back(s_word(1, 0, 12'h300));
        prog.push_back(b_word(1, 3, 13'd16));   // unequal so it falls through
        run_program("beq", 7);
        check("beq taken", 32'd24, pc_trace[4]);
        check("beq not taken", 32'd28, pc_trace[5]);
        check_stores("beq");
        finish_test("beq");

        new_test();
        prog.push_back(j_word(6, 21'd16));
        gold[6] = RESET_ADDR + 32'd4; // link value
        repeat (3) prog.push_back(s_word(6, 0, 12'h300));
        store_reg(6, 12'h200);
        run_program("jal", 5);
        check("jal target", RESET_ADDR + 32'd16, pc_trace[1]);
        check_stores("jal");
        finish_test("jal");

        new_test();
        set_reg(7, 12'd123);
        prog.push_back({20'h5_5555, 5'd7, 7'b0001011}); // custom-0 opcode with rd x7
        store_reg(7, 12'h104);
        run_program("unknown_op", 3);
        check("unknown_op pc", 32'd8, pc_trace[2]);
        check("unknown_op strobe", 32'd0, wr_trace[1]);
        check_stores("unknown_op");
        finish_test("unknown_op");

        $display("tests %0d, passed %0d, failed %0d", tests, tests - failed_tests, failed_tests);
        if (failed_tests == 0 && errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: test/riscv_core_assert.sv
`timescale 1ns/100ps

module riscv_core_assert import riscv_isa_pkg::*; #(
    parameter int              XLEN       = 32,
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input logic            clk_i,
    input logic            rst_i,
    input logic [31:0]     instr_i,
    input logic [XLEN-1:0] pc_o,
    input logic            mem_write_o
);

    int unsigned fail_count = 0; // summed into the testbench error total
    logic [6:0]  op;
    logic        redirect;

    assign op       = instr_i[6:0];
    assign redirect = (op == OP_JAL) || (op == OP_BRANCH); // only these may leave pc + 4

    store_strobe: assert property (@(posedge clk_i) mem_write_o |-> (op == OP_STORE))
        else begin
            $error("mem_write_o high for opcode %b", op);
            fail_count++;
        end

    pc_step: assert property (@(posedge clk_i)
        (!rst_i && !redirect) |=> (pc_o == $past(pc_o) + XLEN'(4)))
        else begin
            $error("pc did not advance by 4 after a sequential instruction");
            fail_count++;
        end

    // first cycle out of reset fetches from the reset vector
    pc_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> (pc_o == RESET_ADDR))
        else begin
            $error("pc_o is %h after reset release", pc_o);
            fail_count++;
        end

endmodule

// File: src/riscv_core.sv
`timescale 1ns/100ps

module riscv_core import riscv_isa_pkg::*, riscv_ctrl_pkg::*; #(
    parameter int              XLEN       = 32,
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] read_data_i,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] data_adr_o,
    output logic [XLEN-1:0] write_data_o,
    output logic            mem_write_o
);

    logic            branch, jump, alu_src, reg_write, zero, pc_src;
    result_src_e     result_src;
    imm_src_e        imm_src;
    alu_op_e         alu_op;
    alu_ctrl_e       alu_ctrl;
    logic [XLEN-1:0] pc, pc_plus4, pc_target, pc_next;
    logic [XLEN-1:0] imm_ext, rd1, rd2, src_b, alu_result, result;

    main_decoder u_main_dec (
        .op_i         (opcode_e'(instr_i[6:0])),
        .branch_o     (branch),
        .jump_o       (jump),
        .result_src_o (result_src),
        .mem_write_o  (mem_write_o),
        .alu_src_o    (alu_src),
        .imm_src_o    (imm_src),
        .reg_write_o  (reg_write),
        .alu_op_o     (alu_op)
    );

    alu_decoder u_alu_dec (
        .alu_op_i   (alu_op),
        .funct3_i   (funct3_e'(instr_i[14:12])),
        .funct7b5_i (instr_i[30]),
        .opb5_i     (instr_i[5]),
        .alu_ctrl_o (alu_ctrl)
    );

    imm_extend #(.XLEN(XLEN)) u_imm (
        .instr_i   (instr_i[31:7]),
        .imm_src_i (imm_src),
        .imm_ext_o (imm_ext)
    );

    reg_file #(.XLEN(XLEN)) u_rf (
        .clk_i (clk_i),
        .we_i  (reg_write & ~rst_i), // no writeback while in reset
        .ra1_i (instr_i[19:15]),
        .ra2_i (instr_i[24:20]),
        .wa_i  (instr_i[11:7]),
        .wd_i  (result),
        .rd1_o (rd1),
        .rd2_o (rd2)
    );

    assign src_b = alu_src ? imm_ext : rd2;

    alu #(.XLEN(XLEN)) u_alu (
        .a_i        (rd1),
        .b_i        (src_b),
        .alu_ctrl_i (alu_ctrl),
        .result_o   (alu_result),
        .zero_o     (zero)
    );

    // writeback select
    always_comb begin
        case (result_src)
            RES_MEM: result = read_data_i;
            RES_PC4: result = pc_plus4;
            default: result = alu_result;
        endcase
    end

    // next pc: jal or taken beq go to pc + imm
    assign pc_plus4  = pc + XLEN'(4);
    assign pc_target = pc + imm_ext;
    assign pc_src    = jump | (branch & zero);
    assign pc_next   = pc_src ? pc_target : pc_plus4;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc <= RESET_ADDR;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_o         = pc;
    assign data_adr_o   = alu_result;
    assign write_data_o = rd2; // sw stores rs2

endmodule

// File: src/alu.sv
`timescale 1ns/100ps

module alu import riscv_ctrl_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  alu_ctrl_e       alu_ctrl_i,
    output logic [XLEN-1:0] result_o,
    output logic            zero_o
);

    logic lt_signed;

    assign lt_signed = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (alu_ctrl_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {{(XLEN-1){1'b0}}, lt_signed};
            default: result_o = a_i + b_i;
        endcase
    end

    // beq relies on this after a subtract
    assign zero_o = (result_o == '0);

endmodule

// File: src/reg_file.sv
`timescale 1ns/100ps

module reg_file #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            we_i,
    input  logic [4:0]      ra1_i,
    input  logic [4:0]      ra2_i,
    input  logic [4:0]      wa_i,
    input  logic [XLEN-1:0] wd_i,
    output logic [XLEN-1:0] rd1_o,
    output logic [XLEN-1:0] rd2_o
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            regs[wa_i] <= wd_i; // x0 may be written, reads mask it
        end
    end

    // asynchronous read ports
    assign rd1_o = (ra1_i == 5'd0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? '0 : regs[ra2_i];

endmodule

// File: src/imm_extend.sv
`timescale 1ns/100ps

module imm_extend import riscv_ctrl_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic [31:7]     instr_i,
    input  imm_src_e        imm_src_i,
    output logic [XLEN-1:0] imm_ext_o
);

    logic sign;

    assign sign = instr_i[31]; // every format keeps its sign in bit 31

    always_comb begin
        case (imm_src_i)
            IMM_I: imm_ext_o = {{(XLEN-12){sign}}, instr_i[31:20]};
            IMM_S: imm_ext_o = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: imm_ext_o = {{(XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                                instr_i[11:8], 1'b0};
            IMM_J: imm_ext_o = {{(XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                                instr_i[30:21], 1'b0};
            default: imm_ext_o = {{(XLEN-12){sign}}, instr_i[31:20]};
        endcase
    end

endmodule

// File: src/alu_decoder.sv
`timescale 1ns/100ps

module alu_decoder import riscv_isa_pkg::*, riscv_ctrl_pkg::*; (
    input  alu_op_e   alu_op_i,
    input  funct3_e   funct3_i,
    input  logic      funct7b5_i,
    input  logic      opb5_i,      // set for R-type, clear for OP-IMM
    output alu_ctrl_e alu_ctrl_o
);

    logic r_type_sub;

    // addi with imm[10] set must not turn into sub
    assign r_type_sub = funct7b5_i & opb5_i;

    always_comb begin
        case (alu_op_i)
            ALUOP_ADD: alu_ctrl_o = ALU_ADD; // lw/sw address
            ALUOP_SUB: alu_ctrl_o = ALU_SUB; // beq compare
            ALUOP_FUNCT: begin
                case (funct3_i)
                    F3_ADD_SUB: begin
                        if (r_type_sub) begin
                            alu_ctrl_o = ALU_SUB;
                        end else begin
                            alu_ctrl_o = ALU_ADD;
                        end
                    end
                    F3_SLT:  alu_ctrl_o = ALU_SLT;
                    F3_OR:   alu_ctrl_o = ALU_OR;
                    F3_AND:  alu_ctrl_o = ALU_AND;
                    default: alu_ctrl_o = ALU_ADD; // unsupported funct3
                endcase
            end
            default: alu_ctrl_o = ALU_ADD;
        endcase
    end

endmodule

// File: src/main_decoder.sv
`timescale 1ns/100ps

module main_decoder import riscv_isa_pkg::*, riscv_ctrl_pkg::*; (
    input  opcode_e     op_i,
    output logic        branch_o,
    output logic        jump_o,
    output result_src_e result_src_o,
    output logic        mem_write_o,
    output logic        alu_src_o,    // 1 selects the immediate as operand b
    output imm_src_e    imm_src_o,
    output logic        reg_write_o,
    output alu_op_e     alu_op_o
);

    always_comb begin
        // start from the all-inactive no-op word
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        result_src_o = RES_ALU;
        mem_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        imm_src_o    = IMM_I;
        reg_write_o  = 1'b0;
        alu_op_o     = ALUOP_ADD;

        case (op_i)
            OP_LOAD: begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1; // base + offset
                result_src_o = RES_MEM;
            end
            OP_STORE: begin
                imm_src_o   = IMM_S;
                alu_src_o   = 1'b1;
                mem_write_o = 1'b1;
            end
            OP_REG: begin
                reg_write_o = 1'b1;
                alu_op_o    = ALUOP_FUNCT;
            end
            OP_IMM: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = ALUOP_FUNCT;
            end
            OP_BRANCH: begin
                imm_src_o = IMM_B;
                branch_o  = 1'b1;
                alu_op_o  = ALUOP_SUB; // zero flag tells equality
            end
            OP_JAL: begin
                reg_write_o  = 1'b1;
                imm_src_o    = IMM_J;
                result_src_o = RES_PC4;
                jump_o       = 1'b1;
            end
            default: ; // unknown opcode keeps the inactive word
        endcase
    end

endmodule

// File: src/riscv_ctrl_pkg.sv
package riscv_ctrl_pkg;

    // class of ALU work requested by the main decoder
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00, // address calculation
        ALUOP_SUB   = 2'b01, // compare for beq
        ALUOP_FUNCT = 2'b10  // look at funct3/funct7
    } alu_op_e;

    // operation actually performed by the ALU
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_ctrl_e;

    // immediate layout in the instruction word
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_src_e;

    // what gets written back to rd
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10 // link address for jal
    } result_src_e;

endpackage

// File: src/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011, // lw
        OP_STORE  = 7'b0100011, // sw
        OP_REG    = 7'b0110011, // add, sub, and, or, slt
        OP_IMM    = 7'b0010011, // addi, andi, ori, slti
        OP_BRANCH = 7'b1100011, // beq
        OP_JAL    = 7'b1101111
    } opcode_e;

    // funct3 for the ALU group
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLT     = 3'b010,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // memory and branch funct3 share codes with the ALU group,
    // so they are typed constants on the same enum
    localparam funct3_e F3_LW_SW = F3_SLT;  // word access
    localparam funct3_e F3_BEQ   = F3_ADD_SUB;

    // field positions inside a 32-bit instruction word
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_B5  = 30;

    // all-zero word has no valid opcode, used as a no-op
    localparam logic [31:0] NOP_WORD = 32'h0000_0000;

endpackage
